// ==== hdl/usbEndpointCtrl.sv ====
`include "usbSlave_defs.svh"

module usbEndpointCtrl (
	input busClk,
	input rstSyncToBusClk,
	input [`usbNumEp-1:0] epWrite,
	input usbRegPkg::epCtrlT epWriteData,
	input [`usbNumEp-1:0] setReady,
	input [`usbNumEp-1:0] clrReadyRise,
	output usbRegPkg::epCtrlT [`usbNumEp-1:0] epCtrl
);

	// iso, stall, sequence, enable per endpoint
	logic [`usbNumEp-1:0][3:0] epCfg;
	logic [`usbNumEp-1:0] epReady;

	always_ff @(posedge busClk) begin
		if (rstSyncToBusClk) begin
			epCfg <= '0;
			epReady <= '0;
			epCtrl <= '0;
		end else begin
			for (int i = 0; i < `usbNumEp; i++) begin
				if (epWrite[i]) begin
					epCfg[i] <= {epWriteData[4:2], epWriteData[0]};
				end
				epCtrl[i] <= {epCfg[i][3:1], epReady[i], epCfg[i][0]};
			end
			// software set beats an engine clear
			epReady <= setReady | (epReady & ~clrReadyRise);
		end
	end

	genvar g;
	generate
		for (g = 0; g < `usbNumEp; g++) begin : gReadyChk
			assert property (@(posedge busClk) disable iff (rstSyncToBusClk)
				$rose(epReady[g]) |-> $past(setReady[g]));
		end
	endgenerate

endmodule

// ==== hdl/usbEventPkg.sv ====
package usbEventPkg;

	// vBus change, nak sent, sof, reset, resume, transfer done
	// same bit order for status, clear and mask
	typedef logic [5:0] intVecT;

	// J/K/SE0 style line state as reported by the phy side
	typedef logic [1:0] connStateT;

endpackage

// ==== hdl/usbInputSync.sv ====
`include "usbSlave_defs.svh"

module usbInputSync (
	input busClk,
	input rstSyncToBusClk,
	input sofRxedIn,
	input resetEventIn,
	input resumeIn,
	input transDoneIn,
	input nakSentIn,
	input vBusDetectIn,
	input usbEventPkg::connStateT connectStateIn,
	input [`usbNumEp-1:0] clrEpReady,
	output usbEventPkg::intVecT eventRise,
	output logic [`usbNumEp-1:0] clrReadyRise,
	output logic vBusSync,
	output usbEventPkg::connStateT connStateSync
);
	import usbEventPkg::*;

	localparam int edgeCnt = 5 + `usbNumEp;

	logic [edgeCnt-1:0] edgeIn;
	logic [edgeCnt-1:0] edgeMeta;
	logic [edgeCnt-1:0] edgeSync;
	logic [edgeCnt-1:0] edgeHist;
	logic [edgeCnt-1:0] risePulses;
	logic vBusMeta;
	logic vBusHist;
	connStateT connMeta;

	// event order follows intVecT below the vBus bit
	assign edgeIn = {clrEpReady, nakSentIn, sofRxedIn, resetEventIn, resumeIn, transDoneIn};

	always_ff @(posedge busClk) begin
		if (rstSyncToBusClk) begin
			edgeMeta <= '0;
			edgeSync <= '0;
			edgeHist <= '0;
			vBusMeta <= 1'b0;
			vBusSync <= 1'b0;
			vBusHist <= 1'b0;
			connMeta <= '0;
			connStateSync <= '0;
			eventRise <= '0;
			clrReadyRise <= '0;
		end else begin
			edgeMeta <= edgeIn;
			edgeSync <= edgeMeta;
			edgeHist <= edgeSync;
			vBusMeta <= vBusDetectIn;
			vBusSync <= vBusMeta;
			vBusHist <= vBusSync;
			connMeta <= connectStateIn;
			connStateSync <= connMeta;
			// vbus flags any change, the others only a rising edge
			eventRise <= {vBusSync ^ vBusHist, edgeSync[4:0] & ~edgeHist[4:0]};
			clrReadyRise <= edgeSync[edgeCnt-1:5] & ~edgeHist[edgeCnt-1:5];
		end
	end

	assign risePulses = {clrReadyRise, eventRise[4:0]};

	// a held input must give a single pulse, not one per cycle
	assert property (@(posedge busClk) disable iff (rstSyncToBusClk)
		(risePulses & $past(risePulses)) == '0);

endmodule

// ==== hdl/usbIntCtrl.sv ====
module usbIntCtrl (
	input busClk,
	input rstSyncToBusClk,
	input usbEventPkg::intVecT eventRise,
	input usbEventPkg::intVecT intClear,
	input usbEventPkg::intVecT intMask,
	output usbEventPkg::intVecT intStatus,
	output usbEventPkg::intVecT intOut
);

	// a new event beats a clear of the same sticky bit
	always_ff @(posedge busClk) begin
		if (rstSyncToBusClk) begin
			intStatus <= '0;
		end else begin
			intStatus <= eventRise | (intStatus & ~intClear);
		end
	end

	assign intOut = intStatus & intMask;

	// masked sources stay quiet on the interrupt lines
	assert property (@(posedge busClk) disable iff (rstSyncToBusClk)
		(intOut & ~intMask) == '0);

endmodule

// ==== hdl/usbRegPkg.sv ====
`include "usbSlave_defs.svh"

package usbRegPkg;

	typedef logic [`usbAddrWidth-1:0] busAddrT;
	typedef logic [`usbDataWidth-1:0] busDataT;

	// iso enable, send stall, data sequence, ready, enable
	typedef logic [4:0] epCtrlT;

	// connect, fs rate, fs polarity, direct control, tx line state[1:0], global enable
	typedef logic [6:0] scCtrlT;

	typedef logic [6:0] devAddrT;

endpackage

// ==== hdl/usbRegRead.sv ====
`include "usbSlave_defs.svh"

module usbRegRead (
	input usbRegPkg::busAddrT address,
	input usbRegPkg::epCtrlT [`usbNumEp-1:0] epCtrl,
	input usbRegPkg::scCtrlT scCtrl,
	input usbRegPkg::devAddrT devAddr,
	input usbEventPkg::intVecT intStatus,
	input usbEventPkg::intVecT intMask,
	input vBusSync,
	input usbEventPkg::connStateT connStateSync,
	output usbRegPkg::busDataT dataOut
);
	import usbRegPkg::*;

	localparam int epIdxW = $clog2(`usbNumEp);

	logic [epIdxW-1:0] epIdx;
	logic epHit;

	assign epIdx = epIdxW'(address / `usbEpStride);
	assign epHit = (address < `usbNumEp * `usbEpStride) && (address % `usbEpStride == 0);

	// status, transfer type and frame number slots are gone and read zero
	always_comb begin
		dataOut = '0;
		if (epHit) begin
			dataOut = busDataT'(epCtrl[epIdx]);
		end else begin
			case (address)
				`usbAddrScCtrl: dataOut = busDataT'(scCtrl);
				`usbAddrConnState: dataOut = busDataT'({vBusSync, connStateSync});
				`usbAddrIntStatus: dataOut = busDataT'(intStatus);
				`usbAddrIntMask: dataOut = busDataT'(intMask);
				`usbAddrDevAddr: dataOut = busDataT'(devAddr);
				default: dataOut = '0;
			endcase
		end
	end

endmodule

// ==== hdl/usbRegWrite.sv ====
`include "usbSlave_defs.svh"

module usbRegWrite (
	input busClk,
	input rstSyncToBusClk,
	input usbRegPkg::busAddrT address,
	input usbRegPkg::busDataT dataIn,
	input writeEn,
	input strobeIn,
	input slaveControlSelect,
	output usbRegPkg::scCtrlT scCtrl,
	output usbRegPkg::devAddrT devAddr,
	output usbEventPkg::intVecT intMask,
	output usbEventPkg::intVecT intClear,
	output logic [`usbNumEp-1:0] epWrite,
	output usbRegPkg::epCtrlT epWriteData,
	output logic [`usbNumEp-1:0] setReady
);
	import usbRegPkg::*;
	import usbEventPkg::*;

	logic wrAccept;

	assign wrAccept = writeEn & strobeIn & slaveControlSelect;
	assign epWriteData = epCtrlT'(dataIn);

	always_comb begin
		for (int i = 0; i < `usbNumEp; i++) begin
			epWrite[i] = wrAccept && (address == busAddrT'(i * `usbEpStride));
		end
	end

	always_ff @(posedge busClk) begin
		if (rstSyncToBusClk) begin
			scCtrl <= '0;
			devAddr <= '0;
			intMask <= '0;
			intClear <= '0;
			setReady <= '0;
		end else begin
			intClear <= '0;
			// ready sits in bit 1 of the endpoint word
			setReady <= epWrite & {`usbNumEp{epWriteData[1]}};
			if (wrAccept) begin
				case (address)
					`usbAddrScCtrl: scCtrl <= scCtrlT'(dataIn);
					`usbAddrDevAddr: devAddr <= devAddrT'(dataIn);
					`usbAddrIntMask: intMask <= intVecT'(dataIn);
					// write one to clear
					`usbAddrIntStatus: intClear <= intVecT'(dataIn);
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge busClk) disable iff (rstSyncToBusClk) $onehot0(epWrite));

endmodule

// ==== hdl/usbSlaveControl.sv ====
`include "usbSlave_defs.svh"

module usbSlaveControl (
	input busClk,
	input rstSyncToBusClk,
	input usbRegPkg::busAddrT address,
	input usbRegPkg::busDataT dataIn,
	input writeEn,
	input strobeIn,
	input slaveControlSelect,
	output usbRegPkg::busDataT dataOut,
	input sofRxedIn,
	input resetEventIn,
	input resumeIn,
	input transDoneIn,
	input nakSentIn,
	input vBusDetectIn,
	input usbEventPkg::connStateT connectStateIn,
	input [`usbNumEp-1:0] clrEpReady,
	output usbRegPkg::epCtrlT [`usbNumEp-1:0] epCtrl,
	output usbRegPkg::scCtrlT scCtrl,
	output usbRegPkg::devAddrT devAddr,
	output usbEventPkg::intVecT intOut
);
	import usbRegPkg::*;
	import usbEventPkg::*;

	intVecT eventRise;
	intVecT intClear;
	intVecT intMask;
	intVecT intStatus;
	logic [`usbNumEp-1:0] clrReadyRise;
	logic [`usbNumEp-1:0] epWrite;
	logic [`usbNumEp-1:0] setReady;
	epCtrlT epWriteData;
	logic vBusSync;
	connStateT connStateSync;

	usbInputSync usbInputSync_inst (
		.busClk(busClk),
		.rstSyncToBusClk(rstSyncToBusClk),
		.sofRxedIn(sofRxedIn),
		.resetEventIn(resetEventIn),
		.resumeIn(resumeIn),
		.transDoneIn(transDoneIn),
		.nakSentIn(nakSentIn),
		.vBusDetectIn(vBusDetectIn),
		.connectStateIn(connectStateIn),
		.clrEpReady(clrEpReady),
		.eventRise(eventRise),
		.clrReadyRise(clrReadyRise),
		.vBusSync(vBusSync),
		.connStateSync(connStateSync)
	);

	usbRegWrite usbRegWrite_inst (
		.busClk(busClk),
		.rstSyncToBusClk(rstSyncToBusClk),
		.address(address),
		.dataIn(dataIn),
		.writeEn(writeEn),
		.strobeIn(strobeIn),
		.slaveControlSelect(slaveControlSelect),
		.scCtrl(scCtrl),
		.devAddr(devAddr),
		.intMask(intMask),
		.intClear(intClear),
		.epWrite(epWrite),
		.epWriteData(epWriteData),
		.setReady(setReady)
	);

	usbIntCtrl usbIntCtrl_inst (
		.busClk(busClk),
		.rstSyncToBusClk(rstSyncToBusClk),
		.eventRise(eventRise),
		.intClear(intClear),
		.intMask(intMask),
		.intStatus(intStatus),
		.intOut(intOut)
	);

	usbEndpointCtrl usbEndpointCtrl_inst (
		.busClk(busClk),
		.rstSyncToBusClk(rstSyncToBusClk),
		.epWrite(epWrite),
		.epWriteData(epWriteData),
		.setReady(setReady),
		.clrReadyRise(clrReadyRise),
		.epCtrl(epCtrl)
	);

	usbRegRead usbRegRead_inst (
		.address(address),
		.epCtrl(epCtrl),
		.scCtrl(scCtrl),
		.devAddr(devAddr),
		.intStatus(intStatus),
		.intMask(intMask),
		.vBusSync(vBusSync),
		.connStateSync(connStateSync),
		.dataOut(dataOut)
	);

endmodule

// ==== hdl/usbSlave_defs.svh ====
`ifndef usbSlaveDefsSvh
`define usbSlaveDefsSvh

// processor bus
`define usbAddrWidth 5
`define usbDataWidth 8

// endpoint control words sit at 0, 4, 8 and 12
`define usbNumEp 4
`define usbEpStride 4

// register address map
`define usbAddrScCtrl 5'd16
`define usbAddrConnState 5'd17
`define usbAddrIntStatus 5'd18
`define usbAddrIntMask 5'd19
`define usbAddrDevAddr 5'd20

`endif

// ==== runSim.sh ====
#!/bin/sh
# builds and runs the usbSlaveControl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module usbSlaveControlTb \
	-f usbSlaveControl.f --Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
	exit 1
fi
exit 0

// ==== tb/usbSlaveControlTb.sv ====
`include "usbSlave_defs.svh"

module usbSlaveControlTb;
	import usbRegPkg::*;
	import usbEventPkg::*;

	// estimated bus cycles of each test, in run order
	localparam int testCycles = 60 + 50 + 60 + 90 + 30 + 40;

	logic busClk = 1'b0;
	logic rstSyncToBusClk;
	busAddrT address;
	busDataT dataIn;
	busDataT dataOut;
	logic writeEn, strobeIn, slaveControlSelect;
	logic sofRxedIn, resetEventIn, resumeIn, transDoneIn, nakSentIn;
	logic vBusDetectIn;
	connStateT connectStateIn;
	logic [3:0] clrEpReady;
	epCtrlT [3:0] epCtrl;
	scCtrlT scCtrl;
	devAddrT devAddr;
	intVecT intOut;

	// event inputs in interrupt bit order
	logic [4:0] evIn;
	int errCount = 0;
	int checkCount = 0;
	int errMark;
	busDataT expScCtrl, expDevAddr, expMask;
	epCtrlT expEp [4];

	assign {nakSentIn, sofRxedIn, resetEventIn, resumeIn, transDoneIn} = evIn;

	always #5 busClk = ~busClk;

	usbSlaveControl usbSlaveControl_inst (.*);

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errCount++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic busWrite(input busAddrT addr, input busDataT data);
		@(posedge busClk);
		address <= addr;
		dataIn <= data;
		writeEn <= 1'b1;
		strobeIn <= 1'b1;
		slaveControlSelect <= 1'b1;
		@(posedge busClk);
		writeEn <= 1'b0;
		strobeIn <= 1'b0;
		slaveControlSelect <= 1'b0;
	endtask

	task automatic readCheck(input busAddrT addr, input busDataT expected, input string name);
		@(posedge busClk);
		address <= addr;
		@(negedge busClk);
		checkValue(name, expected, dataOut);
	endtask

	// samples once per cycle until the value shows up or the limit runs out
	task automatic pollRead(input busAddrT addr, input busDataT expected, input int limit,
		input string name);
		busDataT seen;
		@(posedge busClk);
		address <= addr;
		for (int n = 0; n < limit; n++) begin
			@(negedge busClk);
			seen = dataOut;
			if (seen == expected) begin
				break;
			end
		end
		checkValue(name, expected, seen);
	endtask

	task automatic endTest(input string name);
		$display("test %s finished with %0d errors", name, errCount - errMark);
	endtask

	task automatic testRegRoundTrip();
		busDataT raw;
		errMark = errCount;
		for (int a = 0; a < 32; a++) begin
			readCheck(busAddrT'(a), 8'h00, "dataOut after reset");
		end
		raw = busDataT'($urandom);
		expScCtrl = raw & 8'h7f;
		busWrite(`usbAddrScCtrl, raw);
		raw = busDataT'($urandom);
		expDevAddr = raw & 8'h7f;
		busWrite(`usbAddrDevAddr, raw);
		raw = busDataT'($urandom);
		expMask = raw & 8'h3f;
		busWrite(`usbAddrIntMask, raw);
		readCheck(`usbAddrScCtrl, expScCtrl, "dataOut scCtrl");
		readCheck(`usbAddrDevAddr, expDevAddr, "dataOut devAddr");
		readCheck(`usbAddrIntMask, expMask, "dataOut intMask");
		checkValue("scCtrl", expScCtrl, scCtrl);
		checkValue("devAddr", expDevAddr, devAddr);
		endTest("register round trip");
	endtask

	task automatic testEndpointCtrl();
		busDataT raw;
		errMark = errCount;
		for (int i = 0; i < 4; i++) begin
			// ready held low on the first write
			raw = busDataT'($urandom) & 8'hfd;
			expEp[i] = epCtrlT'(raw & 8'h1d);
			busWrite(busAddrT'(i * 4), raw);
			readCheck(busAddrT'(i * 4), busDataT'(expEp[i]), "dataOut epCtrl");
			checkValue("epCtrl", expEp[i], epCtrl[i]);
			expEp[i] = expEp[i] | 5'h02;
			busWrite(busAddrT'(i * 4), raw | 8'h02);
			pollRead(busAddrT'(i * 4), busDataT'(expEp[i]), 3, "dataOut epCtrl ready");
		end
		endTest("endpoint control");
	endtask

	task automatic testReadyClear();
		errMark = errCount;
		for (int j = 0; j < 4; j++) begin
			@(posedge busClk);
			clrEpReady <= 4'b0001 << j;
			@(posedge busClk);
			clrEpReady <= 4'b0000;
			expEp[j] = expEp[j] & 5'h1d;
			pollRead(busAddrT'(j * 4), busDataT'(expEp[j]), 5, "dataOut ready clear");
			for (int k = 0; k < 4; k++) begin
				readCheck(busAddrT'(k * 4), busDataT'(expEp[k]), "dataOut other ready");
			end
		end
		endTest("ready clear");
	endtask

	task automatic testIntLatch();
		intVecT onBit;
		errMark = errCount;
		for (int b = 0; b < 5; b++) begin
			onBit = intVecT'(1 << b);
			expMask = 8'h00;
			busWrite(`usbAddrIntMask, expMask);
			@(posedge busClk);
			evIn <= onBit[4:0];
			@(posedge busClk);
			evIn <= 5'b00000;
			pollRead(`usbAddrIntStatus, busDataT'(onBit), 6, "dataOut intStatus set");
			checkValue("intOut", 0, intOut);
			expMask = busDataT'(onBit);
			busWrite(`usbAddrIntMask, expMask);
			readCheck(`usbAddrIntStatus, busDataT'(onBit), "dataOut intStatus held");
			checkValue("intOut", onBit, intOut);
			busWrite(`usbAddrIntStatus, busDataT'(onBit));
			readCheck(`usbAddrIntStatus, 8'h00, "dataOut intStatus clear");
			checkValue("intOut", 0, intOut);
		end
		endTest("interrupt latch");
	endtask

	task automatic testVBusConn();
		logic vb;
		connStateT cs;
		errMark = errCount;
		for (int t = 0; t < 2; t++) begin
			// rising change first, then falling
			vb = (t == 0);
			cs = connStateT'($urandom);
			@(posedge busClk);
			vBusDetectIn <= vb;
			connectStateIn <= cs;
			pollRead(`usbAddrIntStatus, 8'h20, 6, "dataOut vBus change");
			pollRead(`usbAddrConnState, busDataT'({vb, cs}), 5, "dataOut connState");
			busWrite(`usbAddrIntStatus, 8'h20);
			readCheck(`usbAddrIntStatus, 8'h00, "dataOut vBus clear");
		end
		endTest("vbus and connect state");
	endtask

	task automatic testUnmapped();
		busAddrT holes [6];
		errMark = errCount;
		holes = '{5'd1, 5'd2, 5'd3, 5'd21, 5'd22, 5'd31};
		foreach (holes[h]) begin
			readCheck(holes[h], 8'h00, "dataOut unmapped");
			busWrite(holes[h], busDataT'($urandom));
			readCheck(holes[h], 8'h00, "dataOut unmapped after write");
		end
		readCheck(`usbAddrScCtrl, expScCtrl, "dataOut scCtrl kept");
		readCheck(`usbAddrDevAddr, expDevAddr, "dataOut devAddr kept");
		readCheck(`usbAddrIntMask, expMask, "dataOut intMask kept");
		readCheck(`usbAddrIntStatus, 8'h00, "dataOut intStatus kept");
		for (int i = 0; i < 4; i++) begin
			readCheck(busAddrT'(i * 4), busDataT'(expEp[i]), "dataOut epCtrl kept");
		end
		endTest("unmapped addresses");
	endtask

	initial begin
		void'($urandom(32'h8c691fcd));
		rstSyncToBusClk = 1'b1;
		address = '0;
		dataIn = '0;
		writeEn = 1'b0;
		strobeIn = 1'b0;
		slaveControlSelect = 1'b0;
		evIn = '0;
		vBusDetectIn = 1'b0;
		connectStateIn = '0;
		clrEpReady = '0;
		repeat (5) @(posedge busClk);
		rstSyncToBusClk <= 1'b0;
		testRegRoundTrip();
		testEndpointCtrl();
		testReadyClear();
		testIntLatch();
		testVBusConn();
		testUnmapped();
		$display("checks run %0d, errors %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// twice the estimated run length plus reset and margin
	initial begin
		#((testCycles * 2 + 50) * 10);
		$display("watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== usbSlaveControl.f ====
+incdir+hdl
hdl/usbRegPkg.sv
hdl/usbEventPkg.sv
hdl/usbInputSync.sv
hdl/usbRegWrite.sv
hdl/usbIntCtrl.sv
hdl/usbEndpointCtrl.sv
hdl/usbRegRead.sv
hdl/usbSlaveControl.sv
tb/usbSlaveControlTb.sv
